/* hw/alu_pkg.sv */
// Shared definitions for the EX1 integer ALU.
// Holds the data widths, the sub-function bit positions of each unit,
// the vector types, the unit select enum and the issue and completion
// structs. Every ALU module imports this package in its header.

package alu_pkg;

  // ==========================================================================
  // Widths
  // ==========================================================================
  localparam int XLEN       = 32;
  localparam int SHAMT_W    = 5;
  localparam int SUB_FUNC_W = 5;

  typedef logic [XLEN-1:0]       data_t;
  typedef logic [SHAMT_W-1:0]    shamt_t;
  typedef logic [SUB_FUNC_W-1:0] sub_func_t;

  // Unit select carried by an issue
  typedef enum logic [1:0] {
    UNIT_NONE    = 2'd0,
    UNIT_ADDER   = 2'd1,
    UNIT_SHIFTER = 2'd2,
    UNIT_LOGIC   = 2'd3
  } alu_unit_e;

  // ==========================================================================
  // Sub-function bit positions
  // ==========================================================================
  // Adder
  localparam int ADD_BIT    = 0;
  localparam int CMP_BIT    = 1;
  localparam int MINMAX_BIT = 2;
  localparam int MAX_BIT    = 3;
  localparam int SIGNED_BIT = 4;

  // Shifter
  localparam int SLL_BIT = 0;
  localparam int SRL_BIT = 1;
  localparam int SRA_BIT = 2;

  // Logic unit, one-hot
  localparam int AND_BIT = 0;
  localparam int OR_BIT  = 1;
  localparam int XOR_BIT = 2;

  // Issue word, 72 bits
  typedef struct packed {
    logic      valid;
    alu_unit_e unit;
    sub_func_t sub_func;
    data_t     src0;
    data_t     src1;
  } alu_issue_t;

  // Completion word, 33 bits
  typedef struct packed {
    logic  valid;
    data_t rslt;
  } alu_cmplt_t;

endpackage

/* hw/alu_adder.sv */
// Adder unit of the EX1 ALU.
// Computes add, subtract, set-less-than and min/max in signed or
// unsigned order with one adder. Operands and sub-function arrive
// gated by the core, so an unselected adder returns zero.

module alu_adder
  import alu_pkg::*;
(
  input  data_t     src0,
  input  data_t     src1,
  input  sub_func_t sub_func,
  output data_t     rslt
);

  logic  op_add;
  logic  op_cmp;
  logic  op_minmax;
  logic  op_max;
  logic  op_signed;
  logic  op_invert;
  data_t addend;
  logic  carry_in;
  logic  carry_out;
  data_t sum;
  logic  signed_lt;
  logic  unsigned_lt;
  logic  less_than;
  logic  pick_src0;
  data_t slt_res;
  data_t minmax_res;
  data_t cmp_res;

  assign op_add    = sub_func[ADD_BIT];
  assign op_cmp    = sub_func[CMP_BIT];
  assign op_minmax = sub_func[MINMAX_BIT];
  assign op_max    = sub_func[MAX_BIT];
  assign op_signed = sub_func[SIGNED_BIT];

  // Subtract and compare both use src0 + ~src1 + 1
  assign op_invert = !op_add || op_cmp;
  assign addend    = op_invert ? ~src1 : src1;
  assign carry_in  = op_invert;

  assign {carry_out, sum} = {1'b0, src0} + {1'b0, addend} + {{XLEN{1'b0}}, carry_in};

  // ==========================================================================
  // Compare
  // ==========================================================================
  // No borrow out of the subtraction means src0 >= src1
  assign unsigned_lt = !carry_out;

  // Differing signs decide directly, equal signs look at the difference
  assign signed_lt = (src0[XLEN-1] && !src1[XLEN-1])
                   || (!(src0[XLEN-1] ^ src1[XLEN-1]) && sum[XLEN-1]);

  assign less_than = op_signed ? signed_lt : unsigned_lt;

  assign slt_res = {{(XLEN-1){1'b0}}, less_than};

  // Max with src0 not smaller, or min with src0 smaller
  assign pick_src0  = op_max ^ less_than;
  assign minmax_res = pick_src0 ? src0 : src1;

  assign cmp_res = op_minmax ? minmax_res : slt_res;
  assign rslt    = op_cmp ? cmp_res : sum;

endmodule

/* hw/alu_shifter.sv */
// Shift unit of the EX1 ALU.
// One right shifter serves all three shifts. A left shift reverses the
// operand on the way in and the result on the way out. The fill bit is
// the operand's sign only for an arithmetic shift.

module alu_shifter
  import alu_pkg::*;
(
  input  data_t     src0,
  input  shamt_t    shamt,
  input  sub_func_t sub_func,
  output data_t     rslt
);

  logic                   op_left;
  logic                   op_sra;
  logic                   op_any;
  logic                   fill_bit;
  data_t                  shift_in;
  logic signed [XLEN:0]   shift_src;
  logic signed [XLEN:0]   shifted;
  data_t                  res_raw;
  data_t                  res_dir;

  // Mirror a word bit by bit
  function automatic data_t bit_reverse(input data_t value);
    data_t reversed;
    for (int i = 0; i < XLEN; i++)
    begin
      reversed[i] = value[XLEN-1-i];
    end
    return reversed;
  endfunction

  assign op_left = sub_func[SLL_BIT];
  assign op_sra  = sub_func[SRA_BIT];
  assign op_any  = sub_func[SLL_BIT] || sub_func[SRL_BIT] || sub_func[SRA_BIT];

  assign fill_bit = op_sra && src0[XLEN-1];
  assign shift_in = op_left ? bit_reverse(src0) : src0;

  // ==========================================================================
  // Right shifter
  // ==========================================================================
  // Extra top bit carries the fill into the vacated positions
  assign shift_src = {fill_bit, shift_in};
  assign shifted   = shift_src >>> shamt;
  assign res_raw   = shifted[XLEN-1:0];

  assign res_dir = op_left ? bit_reverse(res_raw) : res_raw;

  // No shift requested gives zero
  assign rslt = op_any ? res_dir : '0;

endmodule

/* hw/alu_core.sv */
// Combinational datapath of the EX1 ALU.
// Decodes the unit select, gates the sources and sub-function into each
// unit, computes the logic unit inline and merges the unit results with
// an OR mux. Only the selected unit sees nonzero inputs.

module alu_core
  import alu_pkg::*;
(
  input  alu_unit_e unit,
  input  sub_func_t sub_func,
  input  data_t     src0,
  input  data_t     src1,
  output data_t     rslt
);

  logic      adder_sel;
  logic      shifter_sel;
  logic      logic_sel;
  data_t     adder_src0;
  data_t     adder_src1;
  sub_func_t adder_func;
  data_t     adder_rslt;
  data_t     shifter_src0;
  shamt_t    shifter_shamt;
  sub_func_t shifter_func;
  data_t     shifter_rslt;
  data_t     logic_src0;
  data_t     logic_src1;
  sub_func_t logic_func;
  data_t     logic_rslt;

  assign adder_sel   = (unit == UNIT_ADDER);
  assign shifter_sel = (unit == UNIT_SHIFTER);
  assign logic_sel   = (unit == UNIT_LOGIC);

  // ==========================================================================
  // Adder
  // ==========================================================================
  assign adder_src0 = {XLEN{adder_sel}} & src0;
  assign adder_src1 = {XLEN{adder_sel}} & src1;
  assign adder_func = {SUB_FUNC_W{adder_sel}} & sub_func;

  alu_adder u_adder (
    .src0     (adder_src0),
    .src1     (adder_src1),
    .sub_func (adder_func),
    .rslt     (adder_rslt)
  );

  // ==========================================================================
  // Shifter
  // ==========================================================================
  assign shifter_src0  = {XLEN{shifter_sel}} & src0;
  assign shifter_shamt = {SHAMT_W{shifter_sel}} & src1[SHAMT_W-1:0];
  assign shifter_func  = {SUB_FUNC_W{shifter_sel}} & sub_func;

  alu_shifter u_shifter (
    .src0     (shifter_src0),
    .shamt    (shifter_shamt),
    .sub_func (shifter_func),
    .rslt     (shifter_rslt)
  );

  // ==========================================================================
  // Logic unit and result mux
  // ==========================================================================
  assign logic_src0 = {XLEN{logic_sel}} & src0;
  assign logic_src1 = {XLEN{logic_sel}} & src1;
  assign logic_func = {SUB_FUNC_W{logic_sel}} & sub_func;

  // One-hot select of and, or, xor
  assign logic_rslt = ({XLEN{logic_func[AND_BIT]}} & (logic_src0 & logic_src1))
                    | ({XLEN{logic_func[OR_BIT]}}  & (logic_src0 | logic_src1))
                    | ({XLEN{logic_func[XOR_BIT]}} & (logic_src0 ^ logic_src1));

  // Unselected units return zero
  assign rslt = adder_rslt | shifter_rslt | logic_rslt;

endmodule

/* hw/alu_ex1.sv */
// Top level of the EX1 integer ALU stage.
// Accepts an issue on a rising clock edge when it is valid, selects a
// unit and stall is low. The result appears in the completion register
// one cycle later with valid high. Stall is the only back-pressure.

module alu_ex1
  import alu_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  alu_issue_t issue,
  input  logic       stall,
  output alu_cmplt_t cmplt
);

  logic  accept;
  data_t core_rslt;

  // Issue without a unit is taken but never completes
  assign accept = issue.valid && (issue.unit != UNIT_NONE) && !stall;

  // ==========================================================================
  // Datapath
  // ==========================================================================
  alu_core u_core (
    .unit     (issue.unit),
    .sub_func (issue.sub_func),
    .src0     (issue.src0),
    .src1     (issue.src1),
    .rslt     (core_rslt)
  );

  // ==========================================================================
  // Completion register
  // ==========================================================================
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      cmplt.valid <= 1'b0;
      cmplt.rslt  <= '0;
    end
    else
    begin
      cmplt.valid <= accept;
      // Result holds while nothing is accepted
      if (accept)
      begin
        cmplt.rslt <= core_rslt;
      end
    end
  end

endmodule

/* sim/alu_props.sv */
// Handshake assertions for the EX1 ALU top level.
// Bound into alu_ex1 and sampled on the rising clock edge.

module alu_props
  import alu_pkg::*;
(
  input logic       clk,
  input logic       reset,
  input alu_issue_t issue,
  input logic       stall,
  input alu_cmplt_t cmplt
);

  // Assertion failures so far, read by the testbench top
  int fail_count = 0;

  // Completion clears on the edge after reset
  a_reset_clears: assert property (@(posedge clk) reset |=> !cmplt.valid)
    else
    begin
      $error("completion valid in the cycle after reset");
      fail_count = fail_count + 1;
    end

  // Every completion traces back to an accepted issue
  a_valid_source: assert property (@(posedge clk) disable iff (reset)
    cmplt.valid |-> $past(issue.valid && (issue.unit != UNIT_NONE) && !stall))
    else
    begin
      $error("completion valid without an accepted issue one cycle earlier");
      fail_count = fail_count + 1;
    end

  a_rslt_known: assert property (@(posedge clk) disable iff (reset)
    cmplt.valid |-> !$isunknown(cmplt.rslt))
    else
    begin
      $error("completion result has unknown bits while valid");
      fail_count = fail_count + 1;
    end

endmodule

bind alu_ex1 alu_props u_props (
  .clk   (clk),
  .reset (reset),
  .issue (issue),
  .stall (stall),
  .cmplt (cmplt)
);

/* sim/alu_monitor.sv */
// Checker for the EX1 ALU testbench.
// Samples issue and stall on each rising edge, models acceptance and the
// one-cycle latency, and compares the completion at the falling edge.
// Prints one line per finished test and a closing count line.

module alu_monitor
  import alu_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  alu_issue_t issue,
  input  logic       stall,
  input  alu_cmplt_t cmplt,
  input  int         test_idx,
  input  logic       test_end,
  input  logic       run_end,
  output int         err_count
);

  logic  exp_valid;
  data_t exp_rslt;
  logic  was_reset;
  logic  edge_seen;
  int    cmplt_total;
  int    tests_done;
  int    cmplt_base;
  int    err_base;

  function automatic string test_name(input int idx);
    case (idx)
      1: return "add/sub";
      2: return "compare and min/max";
      3: return "shifts";
      4: return "logic";
      5: return "handshake mix";
      default: return "unknown";
    endcase
  endfunction

  // ==========================================================================
  // Reference model
  // ==========================================================================
  function automatic data_t expected_result(input alu_issue_t iss);
    data_t a;
    data_t b;
    logic  lt;
    data_t r;
    a = iss.src0;
    b = iss.src1;
    r = '0;
    if (iss.unit == UNIT_ADDER && !iss.sub_func[CMP_BIT])
      r = iss.sub_func[ADD_BIT] ? a + b : a - b;
    else if (iss.unit == UNIT_ADDER)
    begin
      lt = iss.sub_func[SIGNED_BIT] ? ($signed(a) < $signed(b)) : (a < b);
      if (!iss.sub_func[MINMAX_BIT])
        r = {{(XLEN-1){1'b0}}, lt};
      else if (iss.sub_func[MAX_BIT])
        r = lt ? b : a;
      else
        r = lt ? a : b;
    end
    else if (iss.unit == UNIT_SHIFTER)
    begin
      if (iss.sub_func[SLL_BIT])
        r = a << b[SHAMT_W-1:0];
      else if (iss.sub_func[SRL_BIT])
        r = a >> b[SHAMT_W-1:0];
      else if (iss.sub_func[SRA_BIT])
        r = $signed(a) >>> b[SHAMT_W-1:0];
    end
    else if (iss.unit == UNIT_LOGIC)
    begin
      if (iss.sub_func[AND_BIT])
        r = a & b;
      else if (iss.sub_func[OR_BIT])
        r = a | b;
      else if (iss.sub_func[XOR_BIT])
        r = a ^ b;
    end
    return r;
  endfunction

  initial
  begin
    err_count   = 0;
    cmplt_total = 0;
    tests_done  = 0;
    cmplt_base  = 0;
    err_base    = 0;
    exp_valid   = 1'b0;
    exp_rslt    = '0;
    was_reset   = 1'b0;
    edge_seen   = 1'b0;
  end

  // Inputs are stable here, completion is not
  always @(posedge clk)
  begin
    edge_seen = 1'b1;
    was_reset = reset;
    if (reset)
    begin
      exp_valid = 1'b0;
      exp_rslt  = '0;
    end
    else
    begin
      exp_valid = issue.valid && (issue.unit != UNIT_NONE) && !stall;
      if (exp_valid)
        exp_rslt = expected_result(issue);
    end
    if (test_end)
    begin
      $display("test %0d %s: %0d completions, %0d errors, %s", test_idx,
               test_name(test_idx), cmplt_total - cmplt_base, err_count - err_base,
               (err_count == err_base) ? "ok" : "failed");
      cmplt_base = cmplt_total;
      err_base   = err_count;
      tests_done = tests_done + 1;
    end
    if (run_end)
      $display("summary: %0d tests, %0d completions checked, %0d errors",
               tests_done, cmplt_total, err_count);
  end

  // ==========================================================================
  // Completion check
  // ==========================================================================
  // Checks start after the first rising edge
  always @(negedge clk)
  begin
    if (edge_seen)
    begin
      if (was_reset && (cmplt.valid !== 1'b0))
      begin
        $display("completion valid high during reset at %0t", $time);
        err_count = err_count + 1;
      end
      else if (was_reset && (cmplt.rslt !== '0))
      begin
        $display("ERR cmplt.rslt expected %h got %h at %0t",
                 exp_rslt, cmplt.rslt, $time);
        err_count = err_count + 1;
      end
      else if (exp_valid && (cmplt.valid !== 1'b1))
      begin
        $display("missing completion for an accepted issue at %0t", $time);
        err_count = err_count + 1;
      end
      else if (!exp_valid && (cmplt.valid !== 1'b0))
      begin
        $display("unexpected completion with no accepted issue at %0t", $time);
        err_count = err_count + 1;
      end
      else if (exp_valid)
      begin
        cmplt_total = cmplt_total + 1;
        if (cmplt.rslt !== exp_rslt)
        begin
          $display("ERR cmplt.rslt expected %h got %h at %0t",
                   exp_rslt, cmplt.rslt, $time);
          err_count = err_count + 1;
        end
      end
    end
  end

endmodule

/* sim/tb_alu.sv */
// Testbench top for the EX1 integer ALU stage.
// Generates clock and reset, drives random issues from a Galois LFSR
// two time units after each rising edge and runs five tests in a row.
// The monitor does all comparing. A watchdog bounds the run.

module tb_alu
  import alu_pkg::*;
();

  localparam int NUM_TESTS       = 5;
  localparam int ISSUES_PER_TEST = 200;
  localparam int CLK_PERIOD      = 20;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * ISSUES_PER_TEST * 4 + 50;

  logic        clk;
  logic        reset;
  alu_issue_t  issue;
  logic        stall;
  alu_cmplt_t  cmplt;
  int          test_idx;
  logic        test_end;
  logic        run_end;
  int          err_count;
  logic [31:0] lfsr_state;

  // Legal sub-function lists per test
  sub_func_t arith_funcs[2] = '{5'b00001, 5'b00000};
  sub_func_t cmp_funcs[6]   = '{5'b10010, 5'b00010, 5'b10110, 5'b11110, 5'b00110, 5'b01110};
  sub_func_t shift_funcs[3] = '{5'b00001, 5'b00010, 5'b00100};
  sub_func_t logic_funcs[3] = '{5'b00001, 5'b00010, 5'b00100};

  alu_ex1 UUT (
    .clk   (clk),
    .reset (reset),
    .issue (issue),
    .stall (stall),
    .cmplt (cmplt)
  );

  alu_monitor u_monitor (
    .clk       (clk),
    .reset     (reset),
    .issue     (issue),
    .stall     (stall),
    .cmplt     (cmplt),
    .test_idx  (test_idx),
    .test_end  (test_end),
    .run_end   (run_end),
    .err_count (err_count)
  );

  // ==========================================================================
  // Random source
  // ==========================================================================
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val        = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic drive_issue(input int test);
    logic [31:0] bits;
    logic [31:0] a;
    logic [31:0] b;
    alu_unit_e   unit;
    sub_func_t   func;
    take_bits(2, bits);
    issue.valid = (bits[1:0] != 2'b00);
    take_bits(2, bits);
    stall = (bits[1:0] == 2'b11);
    take_bits(32, a);
    take_bits(32, b);
    take_bits(3, bits);
    unit = (test == 3) ? UNIT_SHIFTER : (test == 4) ? UNIT_LOGIC : UNIT_ADDER;
    if (test == 5)
      unit = alu_unit_e'(bits[1:0]);
    take_bits(3, bits);
    case (unit)
      UNIT_ADDER:   func = (test == 2) ? cmp_funcs[bits % 6] : arith_funcs[bits[0]];
      UNIT_SHIFTER: func = shift_funcs[bits[1:0] % 3];
      UNIT_LOGIC:   func = logic_funcs[bits[1:0] % 3];
      default:      func = sub_func_t'(bits);
    endcase
    take_bits(2, bits);
    // Bias compares toward equal values and sign differences
    if (test == 2 && bits[1:0] == 2'd1)
      b = a;
    else if (test == 2 && bits[1:0] == 2'd2)
      b = a ^ 32'h8000_0000;
    else if (test == 2 && bits[1:0] == 2'd3)
      b = a + bits[1:0];
    // Edge shift amounts
    if (test == 3 && bits[1:0] == 2'd0)
      b[4:0] = 5'd0;
    else if (test == 3 && bits[1:0] == 2'd1)
      b[4:0] = 5'd31;
    issue.unit     = unit;
    issue.sub_func = func;
    issue.src0     = a;
    issue.src1     = b;
  endtask

  task automatic run_test(input int test);
    for (int i = 0; i < ISSUES_PER_TEST; i++)
    begin
      drive_issue(test);
      @(posedge clk);
      #2;
    end
    issue.valid = 1'b0;
    stall       = 1'b0;
    @(posedge clk);
    #2;
    test_idx = test;
    test_end = 1'b1;
    @(posedge clk);
    #2;
    test_end = 1'b0;
  endtask

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired, run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial
  begin
    reset      = 1'b1;
    issue      = '0;
    stall      = 1'b0;
    test_idx   = 0;
    test_end   = 1'b0;
    run_end    = 1'b0;
    lfsr_state = 32'd4;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    // One idle cycle, completion must stay low
    @(posedge clk);
    #2;
    for (int t = 1; t <= NUM_TESTS; t++)
    begin
      run_test(t);
    end
    run_end = 1'b1;
    @(posedge clk);
    #1;
    if (err_count == 0 && UUT.u_props.fail_count == 0)
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* tb.f */
hw/alu_pkg.sv
hw/alu_adder.sv
hw/alu_shifter.sv
hw/alu_core.sv
hw/alu_ex1.sv
sim/alu_props.sv
sim/alu_monitor.sv
sim/tb_alu.sv
